/* src/spi_flash_pkg.sv */
package spi_flash_pkg;

    // Lane width of one command byte or of the data phase
    typedef enum logic [1:0] {
        LANE_SINGLE = 2'd0,  // One bit per cycle on io0 / io1
        LANE_DUAL   = 2'd1,  // Two bits per cycle on io1:io0
        LANE_QUAD   = 2'd2,  // Four bits per cycle on io3:io0
        LANE_RSVD   = 2'd3   // Reserved, runs as single
    } lane_mode_e;

    // Command buffer size in bytes
    localparam int MAX_CMD_BYTES = 12;

    // Twelve command byte fields plus the data mode field
    localparam int LANE_FIELD_BITS = 26;

endpackage

/* src/spi_flash_sequencer.sv */
`timescale 1ns/1ns

module spi_flash_sequencer
    import spi_flash_pkg::*;
(
    input  logic                       i_clk_spi_flash,
    input  logic                       ahbrst,
    input  logic                       i_start,
    input  logic [3:0]                 i_cmd_count,
    input  logic [8*MAX_CMD_BYTES-1:0] i_cmd_bytes,
    input  logic [LANE_FIELD_BITS-1:0] i_lane_modes,
    input  logic [23:0]                i_read_bytes,
    input  logic                       i_fifo_full,
    input  logic                       i_dma_idle,
    output logic [3:0]                 o_so,
    output logic [3:0]                 o_oen,         // Active low
    output logic                       o_csn,
    output logic                       o_clk_en,
    output logic                       o_xfer_start,  // One cycle pulse
    output logic                       o_rx_sample,
    output lane_mode_e                 o_rx_mode
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CMD  = 2'd1;
    localparam logic [1:0] ST_READ = 2'd2;

    logic [1:0]  state;
    logic        start_q;
    logic        start_d;
    logic        start_rise;
    logic [3:0]  cmd_idx;     // Command byte being shifted
    logic [2:0]  bit_cnt;     // Bits done in the current byte
    logic [23:0] byte_cnt;    // Data bytes sampled so far
    logic [7:0]  cur_byte;
    logic [7:0]  cur_shift;
    lane_mode_e  cmd_mode;
    lane_mode_e  act_mode;
    logic [3:0]  step;
    logic [3:0]  bits_next;
    logic        byte_done;
    logic        cmd_last;
    logic        read_last;

    assign start_rise = start_q & ~start_d;
    assign cur_byte   = i_cmd_bytes[8*cmd_idx +: 8];
    assign cmd_mode   = lane_mode_e'(i_lane_modes[2*cmd_idx +: 2]);
    assign o_rx_mode  = lane_mode_e'(i_lane_modes[LANE_FIELD_BITS-1 -: 2]);
    assign act_mode   = (state == ST_CMD) ? cmd_mode : o_rx_mode;
    assign cur_shift  = cur_byte << bit_cnt;  // Next bits sit at the top

    // Bits moved per cycle with reserved treated as single
    always_comb begin
        case (act_mode)
            LANE_DUAL: step = 4'd2;
            LANE_QUAD: step = 4'd4;
            default:   step = 4'd1;
        endcase
    end

    assign bits_next = {1'b0, bit_cnt} + step;
    assign byte_done = bits_next[3];
    assign cmd_last  = byte_done && (cmd_idx == i_cmd_count - 4'd1);
    assign read_last = byte_done && (byte_cnt == i_read_bytes - 24'd1);

    assign o_csn       = (state == ST_IDLE);
    assign o_rx_sample = (state == ST_READ) && !i_fifo_full;  // Hold while FIFO is full
    assign o_clk_en    = (state == ST_CMD) || o_rx_sample;

    // MSB first onto the lanes of the current byte
    always_comb begin
        o_so  = 4'b0000;
        o_oen = 4'b1111;
        if (state == ST_CMD) begin
            case (cmd_mode)
                LANE_DUAL: begin
                    o_so[1:0] = cur_shift[7:6];
                    o_oen     = 4'b1100;
                end
                LANE_QUAD: begin
                    o_so  = cur_shift[7:4];
                    o_oen = 4'b0000;
                end
                default: begin
                    o_so[0] = cur_shift[7];
                    o_oen   = 4'b1110;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk_spi_flash or negedge ahbrst) begin
        if (!ahbrst) begin
            state        <= ST_IDLE;
            start_q      <= 1'b0;
            start_d      <= 1'b0;
            o_xfer_start <= 1'b0;
            cmd_idx      <= 4'd0;
            bit_cnt      <= 3'd0;
            byte_cnt     <= 24'd0;
        end else begin
            start_q      <= i_start;
            start_d      <= start_q;
            o_xfer_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_rise && i_dma_idle) begin  // Busy write-back drops the edge
                        state        <= ST_CMD;
                        o_xfer_start <= 1'b1;
                        cmd_idx      <= 4'd0;
                        bit_cnt      <= 3'd0;
                        byte_cnt     <= 24'd0;
                    end
                end
                ST_CMD: begin
                    bit_cnt <= bits_next[2:0];  // Wraps to zero at byte end
                    if (byte_done) begin
                        cmd_idx <= cmd_idx + 4'd1;
                        if (cmd_last) begin
                            state <= (i_read_bytes == 24'd0) ? ST_IDLE : ST_READ;
                        end
                    end
                end
                ST_READ: begin
                    if (o_rx_sample) begin
                        bit_cnt <= bits_next[2:0];
                        if (byte_done) begin
                            byte_cnt <= byte_cnt + 24'd1;
                            if (read_last) begin
                                state <= ST_IDLE;
                            end
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Packer and DMA writer only handle whole words
    a_read_word_multiple: assert property (@(posedge i_clk_spi_flash) disable iff (!ahbrst)
        o_xfer_start |-> (i_read_bytes[1:0] == 2'b00))
        else $error("read byte count is not a multiple of 4");

    a_no_rsvd_lane: assert property (@(posedge i_clk_spi_flash) disable iff (!ahbrst)
        !o_csn |-> (act_mode != LANE_RSVD))
        else $error("reserved lane mode used while chip select is low");

endmodule

/* src/spi_flash_rx_packer.sv */
`timescale 1ns/1ns

module spi_flash_rx_packer
    import spi_flash_pkg::*;
(
    input  logic        i_clk_spi_flash,
    input  logic        ahbrst,
    input  logic        i_xfer_start,
    input  logic        i_rx_sample,
    input  lane_mode_e  i_rx_mode,
    input  logic [3:0]  i_si,
    output logic        o_push,
    output logic [31:0] o_word
);

    logic [31:0] shift_q;
    logic [31:0] shift_d;
    logic [4:0]  bit_cnt;    // Bits collected in the current word
    logic [5:0]  bits_next;  // Bit 5 marks a full word

    // First sampled bits end up in the top byte
    always_comb begin
        case (i_rx_mode)
            LANE_DUAL: begin
                shift_d   = {shift_q[29:0], i_si[1:0]};
                bits_next = {1'b0, bit_cnt} + 6'd2;
            end
            LANE_QUAD: begin
                shift_d   = {shift_q[27:0], i_si[3:0]};
                bits_next = {1'b0, bit_cnt} + 6'd4;
            end
            default: begin
                shift_d   = {shift_q[30:0], i_si[1]};  // Single reads from io1
                bits_next = {1'b0, bit_cnt} + 6'd1;
            end
        endcase
    end

    always_ff @(posedge i_clk_spi_flash or negedge ahbrst) begin
        if (!ahbrst) begin
            bit_cnt <= 5'd0;
            o_push  <= 1'b0;
        end else begin
            o_push <= 1'b0;
            if (i_xfer_start) begin
                bit_cnt <= 5'd0;
            end else if (i_rx_sample) begin
                bit_cnt <= bits_next[4:0];
                o_push  <= bits_next[5];  // Word ready next cycle
            end
        end
    end

    always_ff @(posedge i_clk_spi_flash) begin
        if (i_rx_sample) begin
            shift_q <= shift_d;
        end
    end

    assign o_word = shift_q;  // Stable during the push cycle

endmodule

/* src/spi_flash_word_fifo.sv */
`timescale 1ns/1ns

module spi_flash_word_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic        i_clk_spi_flash,
    input  logic        ahbrst,
    input  logic        i_push,
    input  logic [31:0] i_wdata,
    input  logic        i_pop,
    output logic [31:0] o_rdata,
    output logic        o_full,
    output logic        o_empty
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    logic [31:0]     mem [FIFO_DEPTH];
    logic [ADDR_W:0] wr_ptr;  // Extra bit tells full from empty
    logic [ADDR_W:0] rd_ptr;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign o_rdata = mem[rd_ptr[ADDR_W-1:0]];  // Head word

    always_ff @(posedge i_clk_spi_flash) begin
        if (i_push && !o_full) begin
            mem[wr_ptr[ADDR_W-1:0]] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk_spi_flash or negedge ahbrst) begin
        if (!ahbrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push && !o_full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop && !o_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Sequencer stall must keep the packer from overrunning
    a_no_overflow: assert property (@(posedge i_clk_spi_flash) disable iff (!ahbrst)
        i_push |-> !o_full)
        else $error("word FIFO push while full");

    a_no_underflow: assert property (@(posedge i_clk_spi_flash) disable iff (!ahbrst)
        i_pop |-> !o_empty)
        else $error("word FIFO pop while empty");

endmodule

/* src/spi_flash_dma_writer.sv */
`timescale 1ns/1ns

module spi_flash_dma_writer #(
    parameter int BUS_CREDITS = 2
) (
    input  logic        i_clk_spi_flash,
    input  logic        ahbrst,
    input  logic        i_xfer_start,
    input  logic [31:0] i_dma_base,
    input  logic [23:0] i_read_bytes,
    input  logic        i_empty,
    input  logic [31:0] i_rdata,
    input  logic        i_bus_credit,
    output logic        o_pop,
    output logic        o_bus_valid,
    output logic [31:0] o_bus_addr,
    output logic [31:0] o_bus_data,
    output logic        o_irq,
    output logic        o_idle
);

    localparam int CRED_W = $clog2(BUS_CREDITS + 2);  // Room to catch an overflow

    logic [CRED_W-1:0] credits;
    logic [31:0]       addr_q;
    logic [21:0]       word_cnt;     // Words issued this transaction
    logic [21:0]       word_target;
    logic              started;
    logic              send;

    assign word_target = i_read_bytes[23:2];
    assign send        = (credits != '0) && !i_empty;  // Earliest possible cycle
    assign o_bus_valid = send;
    assign o_pop       = send;
    assign o_bus_addr  = addr_q;
    assign o_bus_data  = i_rdata;
    assign o_idle      = o_irq || !started;

    always_ff @(posedge i_clk_spi_flash or negedge ahbrst) begin
        if (!ahbrst) begin
            credits <= CRED_W'(BUS_CREDITS);
        end else begin
            case ({send, i_bus_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // Send and return cancel
            endcase
        end
    end

    always_ff @(posedge i_clk_spi_flash or negedge ahbrst) begin
        if (!ahbrst) begin
            started  <= 1'b0;
            word_cnt <= 22'd0;
            o_irq    <= 1'b0;
        end else if (i_xfer_start) begin
            started  <= 1'b1;
            word_cnt <= 22'd0;
            o_irq    <= (word_target == 22'd0);  // Nothing to write back
        end else if (send) begin
            word_cnt <= word_cnt + 22'd1;
            if (word_cnt + 22'd1 == word_target) begin
                o_irq <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk_spi_flash) begin
        if (i_xfer_start) begin
            addr_q <= i_dma_base;
        end else if (send) begin
            addr_q <= addr_q + 32'd4;  // Next word address
        end
    end

    a_credit_limit: assert property (@(posedge i_clk_spi_flash) disable iff (!ahbrst)
        credits <= CRED_W'(BUS_CREDITS))
        else $error("bus sink returned more credits than were issued");

endmodule

/* src/spi_flash_ctrl.sv */
`timescale 1ns/1ns

module spi_flash_ctrl
    import spi_flash_pkg::*;
#(
    parameter int FIFO_DEPTH  = 4,
    parameter int BUS_CREDITS = 2
) (
    input  logic                       i_clk_spi_flash,
    input  logic                       ahbrst,
    input  logic                       i_start,
    input  logic [3:0]                 i_cmd_count,
    input  logic [8*MAX_CMD_BYTES-1:0] i_cmd_bytes,
    input  logic [LANE_FIELD_BITS-1:0] i_lane_modes,
    input  logic [23:0]                i_read_bytes,
    input  logic [31:0]                i_dma_base,
    output logic [3:0]                 o_so,
    output logic [3:0]                 o_oen,
    output logic                       o_csn,
    output logic                       o_clk_en,
    input  logic [3:0]                 i_si,
    output logic                       o_bus_valid,
    output logic [31:0]                o_bus_addr,
    output logic [31:0]                o_bus_data,
    input  logic                       i_bus_credit,
    output logic                       o_irq
);

    logic        xfer_start;
    logic        rx_sample;
    lane_mode_e  rx_mode;
    logic        push;
    logic [31:0] word;
    logic        fifo_full;
    logic        fifo_empty;
    logic [31:0] fifo_rdata;
    logic        pop;
    logic        dma_idle;

    spi_flash_sequencer u_sequencer (
        .i_clk_spi_flash (i_clk_spi_flash),
        .ahbrst          (ahbrst),
        .i_start         (i_start),
        .i_cmd_count     (i_cmd_count),
        .i_cmd_bytes     (i_cmd_bytes),
        .i_lane_modes    (i_lane_modes),
        .i_read_bytes    (i_read_bytes),
        .i_fifo_full     (fifo_full),
        .i_dma_idle      (dma_idle),
        .o_so            (o_so),
        .o_oen           (o_oen),
        .o_csn           (o_csn),
        .o_clk_en        (o_clk_en),
        .o_xfer_start    (xfer_start),
        .o_rx_sample     (rx_sample),
        .o_rx_mode       (rx_mode)
    );

    spi_flash_rx_packer u_rx_packer (
        .i_clk_spi_flash (i_clk_spi_flash),
        .ahbrst          (ahbrst),
        .i_xfer_start    (xfer_start),
        .i_rx_sample     (rx_sample),
        .i_rx_mode       (rx_mode),
        .i_si            (i_si),
        .o_push          (push),
        .o_word          (word)
    );

    spi_flash_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_word_fifo (
        .i_clk_spi_flash (i_clk_spi_flash),
        .ahbrst          (ahbrst),
        .i_push          (push),
        .i_wdata         (word),
        .i_pop           (pop),
        .o_rdata         (fifo_rdata),
        .o_full          (fifo_full),
        .o_empty         (fifo_empty)
    );

    spi_flash_dma_writer #(
        .BUS_CREDITS (BUS_CREDITS)
    ) u_dma_writer (
        .i_clk_spi_flash (i_clk_spi_flash),
        .ahbrst          (ahbrst),
        .i_xfer_start    (xfer_start),
        .i_dma_base      (i_dma_base),
        .i_read_bytes    (i_read_bytes),
        .i_empty         (fifo_empty),
        .i_rdata         (fifo_rdata),
        .i_bus_credit    (i_bus_credit),
        .o_pop           (pop),
        .o_bus_valid     (o_bus_valid),
        .o_bus_addr      (o_bus_addr),
        .o_bus_data      (o_bus_data),
        .o_irq           (o_irq),
        .o_idle          (dma_idle)
    );

endmodule

/* testbench/spi_flash_model.sv */
`timescale 1ns/1ns

module spi_flash_model
    import spi_flash_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_csn,
    input  logic       i_clk_en,
    input  logic [3:0] i_so,
    input  logic [3:0] i_oen,
    input  lane_mode_e i_data_mode,
    output logic [3:0] o_si
);

    logic [7:0]  cap_bytes [MAX_CMD_BYTES];
    lane_mode_e  cap_modes [MAX_CMD_BYTES];
    int          cap_cnt = 0;           // Command bytes seen this transaction
    int          cap_bits = 0;
    int          step;
    logic [7:0]  cap_shift;
    lane_mode_e  seen_mode;
    lane_mode_e  byte_mode;
    logic        csn_q = 1'b1;
    logic [31:0] lfsr_q = 32'hfe49_4b69;
    logic [31:0] lfsr_d;
    logic [3:0]  data_bits;
    int          n;

    // Fibonacci taps 32 22 2 1 with the new bit entering at bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Earliest bit of the next read sample goes on the highest lane
    always_comb begin
        case (i_data_mode)
            LANE_QUAD: n = 4;
            LANE_DUAL: n = 2;
            default:   n = 1;
        endcase
        lfsr_d    = lfsr_q;
        data_bits = 4'b0000;
        for (int i = 0; i < n; i++) begin
            lfsr_d    = lfsr_next(lfsr_d);
            data_bits = {data_bits[2:0], lfsr_d[0]};
        end
        o_si = (n == 1) ? {2'b00, data_bits[0], 1'b0} : data_bits;  // Single drives io1
    end

    always @(posedge i_clk) begin
        csn_q <= i_csn;
        if (!i_csn && csn_q) begin
            cap_cnt  = 0;  // New transaction
            cap_bits = 0;
        end
        if (!i_csn && i_clk_en) begin
            if (i_oen == 4'b1111) begin
                lfsr_q <= lfsr_d;  // Data phase sample taken
            end else begin
                case (i_oen)
                    4'b0000: begin
                        cap_shift = {cap_shift[3:0], i_so};
                        step      = 4;
                        seen_mode = LANE_QUAD;
                    end
                    4'b1100: begin
                        cap_shift = {cap_shift[5:0], i_so[1:0]};
                        step      = 2;
                        seen_mode = LANE_DUAL;
                    end
                    default: begin
                        cap_shift = {cap_shift[6:0], i_so[0]};
                        step      = 1;
                        seen_mode = (i_oen == 4'b1110) ? LANE_SINGLE : LANE_RSVD;
                    end
                endcase
                if (cap_bits == 0) begin
                    byte_mode = seen_mode;
                end else if (byte_mode != seen_mode) begin
                    byte_mode = LANE_RSVD;  // Lanes changed inside one byte
                end
                cap_bits = cap_bits + step;
                if (cap_bits >= 8) begin
                    if (cap_cnt < MAX_CMD_BYTES) begin
                        cap_bytes[cap_cnt] = cap_shift;
                        cap_modes[cap_cnt] = byte_mode;
                    end
                    cap_cnt  = cap_cnt + 1;
                    cap_bits = 0;
                end
            end
        end
    end

endmodule

/* testbench/tb_spi_flash_ctrl.sv */
`timescale 1ns/1ns

module tb_spi_flash_ctrl
    import spi_flash_pkg::*;
();

    localparam int WAIT_LIMIT = 4000;  // Cycles allowed per wait
    localparam int W_CSN_LOW  = 0;
    localparam int W_CSN_HIGH = 1;
    localparam int W_IRQ      = 2;
    localparam int W_DRAINED  = 3;

    logic                       clk;
    logic                       ahbrst;
    logic                       start;
    logic [3:0]                 cmd_count;
    logic [8*MAX_CMD_BYTES-1:0] cmd_bytes;
    logic [LANE_FIELD_BITS-1:0] lane_modes;
    logic [23:0]                read_bytes;
    logic [31:0]                dma_base;
    logic [3:0]                 si;
    logic                       bus_credit;
    logic [3:0]                 so;
    logic [3:0]                 oen;
    logic                       csn;
    logic                       clk_en;
    logic                       bus_valid;
    logic [31:0]                bus_addr;
    logic [31:0]                bus_data;
    logic                       irq;
    lane_mode_e                 data_mode;

    logic [31:0] lfsr;            // Predicted flash data stream
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    int          credit_due [$];  // Cycle at which each credit goes back
    int          credit_delay;
    int          cyc;
    int          csn_falls;
    logic        csn_q;
    logic        stall_seen;

    assign data_mode = lane_mode_e'(lane_modes[LANE_FIELD_BITS-1 -: 2]);

    spi_flash_ctrl #(
        .FIFO_DEPTH  (4),
        .BUS_CREDITS (2)
    ) i_spi_flash_ctrl (
        .i_clk_spi_flash (clk),
        .ahbrst          (ahbrst),
        .i_start         (start),
        .i_cmd_count     (cmd_count),
        .i_cmd_bytes     (cmd_bytes),
        .i_lane_modes    (lane_modes),
        .i_read_bytes    (read_bytes),
        .i_dma_base      (dma_base),
        .o_so            (so),
        .o_oen           (oen),
        .o_csn           (csn),
        .o_clk_en        (clk_en),
        .i_si            (si),
        .o_bus_valid     (bus_valid),
        .o_bus_addr      (bus_addr),
        .o_bus_data      (bus_data),
        .i_bus_credit    (bus_credit),
        .o_irq           (irq)
    );

    spi_flash_model u_flash_model (
        .i_clk       (clk),
        .i_csn       (csn),
        .i_clk_en    (clk_en),
        .i_so        (so),
        .i_oen       (oen),
        .i_data_mode (data_mode),
        .o_si        (si)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Bus sink with delayed credit return and chip select watch
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (bus_valid) begin
            got_addr.push_back(bus_addr);
            got_data.push_back(bus_data);
            credit_due.push_back(cyc + credit_delay);
        end
        if (credit_due.size() > 0 && credit_due[0] <= cyc) begin
            bus_credit = 1'b1;
            void'(credit_due.pop_front());
        end else begin
            bus_credit = 1'b0;
        end
        if (!csn && csn_q) begin
            csn_falls = csn_falls + 1;
        end
        if (!csn && !clk_en) begin
            stall_seen = 1'b1;  // Read phase held off
        end
        csn_q = csn;
    end

    // Same taps as the flash model
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] predict_byte();
        logic [7:0] b;
        b = 8'h00;
        for (int k = 0; k < 8; k++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};  // First bit is the MSB
        end
        return b;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_mode(input string name, input lane_mode_e got, input lane_mode_e exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_lanes(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic reached(input int what);
        case (what)
            W_CSN_LOW:  return csn === 1'b0;
            W_CSN_HIGH: return csn === 1'b1;
            W_IRQ:      return irq === 1'b1;
            default:    return credit_due.size() == 0 && bus_credit === 1'b0;
        endcase
    endfunction

    task automatic wait_until(input int what, input string name);
        int n;
        n = 0;
        while (!reached(what)) begin
            @(negedge clk);
            n = n + 1;
            if (n > WAIT_LIMIT) begin
                abort_run($sformatf("timeout after %0d cycles waiting for %s", n, name));
            end
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // One transaction, then command capture, bus words and interrupt checks
    task automatic run_xfer(input int ncmd, input logic [95:0] bytes, input logic [25:0] modes,
                            input int nread, input logic [31:0] base, input int extra_starts);
        int          falls_before;
        logic [31:0] exp_word;
        @(negedge clk);
        cmd_count    = 4'(ncmd);
        cmd_bytes    = bytes;
        lane_modes   = modes;
        read_bytes   = 24'(nread);
        dma_base     = base;
        got_addr.delete();
        got_data.delete();
        stall_seen   = 1'b0;
        falls_before = csn_falls;
        start        = 1'b1;
        wait_until(W_CSN_LOW, "chip select low");
        start = 1'b0;
        @(negedge clk);
        if (nread != 0 && irq !== 1'b0) begin
            abort_run("interrupt still high after the next transaction started");
        end
        repeat (extra_starts) pulse_start();  // Sequencer busy
        wait_until(W_CSN_HIGH, "chip select high");
        repeat (extra_starts) pulse_start();  // Write-back busy
        wait_until(W_IRQ, "done interrupt");
        wait_until(W_DRAINED, "all bus credits returned");
        repeat (4) @(negedge clk);
        if (csn_falls - falls_before != 1) begin
            abort_run("a start pulse during a busy transaction launched another one");
        end
        check_count("captured command byte count", u_flash_model.cap_cnt, ncmd);
        for (int i = 0; i < ncmd; i++) begin
            check_byte($sformatf("command byte %0d", i), u_flash_model.cap_bytes[i],
                       bytes[8*i +: 8]);
            check_mode($sformatf("command lane mode %0d", i), u_flash_model.cap_modes[i],
                       lane_mode_e'(modes[2*i +: 2]));
        end
        check_count("bus word count", got_data.size(), nread / 4);
        for (int w = 0; w < nread / 4; w++) begin
            exp_word = 32'h0;
            for (int b = 0; b < 4; b++) begin
                exp_word = {exp_word[23:0], predict_byte()};  // Big-endian packing
            end
            check_word($sformatf("o_bus_data word %0d", w), got_data[w], exp_word);
            check_word($sformatf("o_bus_addr word %0d", w), got_addr[w], base + 32'(4 * w));
        end
        check_bit("o_irq", irq, 1'b1);
    endtask

    task automatic reset_outputs_idle();
        @(negedge clk);
        check_bit("o_csn", csn, 1'b1);
        check_bit("o_clk_en", clk_en, 1'b0);
        check_lanes("o_oen", oen, 4'hf);
        check_bit("o_bus_valid", bus_valid, 1'b0);
        check_bit("o_irq", irq, 1'b0);
    endtask

    task automatic single_lane_read();
        credit_delay = 2;
        run_xfer(4, 96'h0000_0000_0000_0000_a5c3_0b03, 26'd0, 8, 32'h2000_0100, 0);
    endtask

    task automatic mixed_lane_read();
        credit_delay = 2;
        run_xfer(5, 96'h0000_0000_0000_00e7_5a96_3cbb,
                 {LANE_QUAD, 14'd0, LANE_DUAL, LANE_QUAD, LANE_SINGLE, LANE_QUAD, LANE_DUAL},
                 16, 32'h3000_0000, 0);
    endtask

    task automatic zero_byte_command();
        credit_delay = 2;
        run_xfer(3, 96'h0000_0000_0000_0000_009f_66ab, 26'd0, 0, 32'h4000_0000, 0);
    endtask

    // Slow sink lets the FIFO fill up and stall the read phase
    task automatic credit_backpressure();
        credit_delay = 300;
        run_xfer(1, 96'h6b, {LANE_DUAL, 24'd0}, 32, 32'h0000_1ff8, 0);
        if (!stall_seen) begin
            abort_run("read clock never stalled while the word FIFO was full");
        end
        credit_delay = 2;
    endtask

    task automatic ignored_busy_starts();
        credit_delay = 150;
        run_xfer(1, 96'h0b, 26'd0, 16, 32'h5000_0040, 2);
        credit_delay = 2;
        run_xfer(2, 96'h003b, {LANE_QUAD, 24'd0}, 8, 32'h5000_0080, 0);  // Clears the interrupt
    endtask

    initial begin
        ahbrst       = 1'b0;
        start        = 1'b0;
        cmd_count    = 4'd0;
        cmd_bytes    = '0;
        lane_modes   = '0;
        read_bytes   = 24'd0;
        dma_base     = 32'd0;
        bus_credit   = 1'b0;
        credit_delay = 2;
        cyc          = 0;
        csn_falls    = 0;
        csn_q        = 1'b1;
        stall_seen   = 1'b0;
        lfsr         = 32'hfe49_4b69;
        repeat (5) @(negedge clk);
        ahbrst = 1'b1;
        reset_outputs_idle();
        single_lane_read();
        mixed_lane_read();
        zero_byte_command();
        credit_backpressure();
        ignored_busy_starts();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* compile.f */
src/spi_flash_pkg.sv
src/spi_flash_sequencer.sv
src/spi_flash_rx_packer.sv
src/spi_flash_word_fifo.sv
src/spi_flash_dma_writer.sv
src/spi_flash_ctrl.sv
testbench/spi_flash_model.sv
testbench/tb_spi_flash_ctrl.sv
